//--- sources.f
+incdir+common
common/eeprom_pkg.sv
verilog/eeprom_cmd_fifo.sv
i2c_master/i2c_sequencer.sv
i2c_master/i2c_bit_engine.sv
verilog/eeprom_ctrl_top.sv
testbench/eeprom_slave_model.sv
testbench/eeprom_ctrl_assertions.sv
testbench/tb_eeprom_ctrl.sv

//--- Bender.yml
package:
  name: eeprom_ctrl

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/eeprom_pkg.sv
      - verilog/eeprom_cmd_fifo.sv
      - i2c_master/i2c_sequencer.sv
      - i2c_master/i2c_bit_engine.sv
      - verilog/eeprom_ctrl_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/eeprom_slave_model.sv
      - testbench/eeprom_ctrl_assertions.sv
      - testbench/tb_eeprom_ctrl.sv

//--- testbench/tb_eeprom_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_cfg.svh"

module tb_eeprom_ctrl;

    localparam int NUM_CMDS    = 55;    // upper bound over all phases
    localparam int BIT_NS      = 4 * `EEPROM_SCL_QUARTER * 4;
    localparam int WATCHDOG_NS = NUM_CMDS * 40 * BIT_NS * 2;

    logic                       CLK;
    logic                       RESET;
    logic                       wr;
    logic                       rd;
    logic [10:0]                addr;
    logic [7:0]                 wdata;
    logic                       full;
    logic                       done;
    eeprom_pkg::eeprom_result_t result;
    logic                       scl;
    logic                       dut_sda_low;
    logic                       slave_sda_low;
    logic                       sda_bus;
    logic                       force_nack;
    eeprom_pkg::eeprom_byte_u   ctrl_wr;
    eeprom_pkg::eeprom_byte_u   ctrl_rd;

    eeprom_pkg::eeprom_result_t exp_q[$];
    logic [10:0]                used_addr[$];
    logic [7:0]                 ref_mem [2048];
    logic                       written [2048];
    int                         done_count = 0;

    assign sda_bus = !(dut_sda_low || slave_sda_low);   // open drain with pull-up

    eeprom_ctrl_top dut0
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wdata   (wdata),
        .sda_in  (sda_bus),
        .full    (full),
        .done    (done),
        .result  (result),
        .scl     (scl),
        .sda_low (dut_sda_low)
    );

    eeprom_slave_model slave0
    (
        .scl        (scl),
        .sda        (sda_bus),
        .force_nack (force_nack),
        .sda_low    (slave_sda_low),
        .ctrl_wr    (ctrl_wr),
        .ctrl_rd    (ctrl_rd)
    );

    bind eeprom_ctrl_top eeprom_ctrl_assertions asrt0 (.*);

    always #2 CLK = ~CLK;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic compare_result(input eeprom_pkg::eeprom_result_t got,
                                  input eeprom_pkg::eeprom_result_t exp);
        if (got !== exp)
            abort_run($sformatf({"** Error at %0t: result rd=%0b nack=%0b addr=%h data=%h,",
                                 " expected rd=%0b nack=%0b addr=%h data=%h"}, $time,
                                got.is_read, got.nack, got.addr, got.data,
                                exp.is_read, exp.nack, exp.addr, exp.data));
    endtask

    task automatic compare_byte(input eeprom_pkg::eeprom_byte_u got,
                                input eeprom_pkg::eeprom_byte_u exp, input string what);
        if (got !== exp)
            abort_run($sformatf("** Error at %0t: %s is %b, expected %b",
                                $time, what, got.raw, exp.raw));
    endtask

    task automatic compare_level(input logic got, input logic exp, input string what);
        if (got !== exp)
            abort_run($sformatf("** Error at %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    // one host strobe and its expected result from the reference memory
    task automatic issue_cmd(input logic is_read, input logic [10:0] a, input logic [7:0] d,
                             input logic nacked);
        eeprom_pkg::eeprom_result_t exp;
        @(negedge CLK);
        while (full)
            @(negedge CLK);
        @(posedge CLK);
        wr    <= !is_read;
        rd    <= is_read;
        addr  <= a;
        wdata <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        exp.is_read = is_read;
        exp.nack    = nacked;
        exp.addr    = a;
        exp.data    = is_read ? ref_mem[a] : d;
        if (!is_read && !nacked)
        begin
            ref_mem[a] = d;
            written[a] = 1'b1;
        end
        exp_q.push_back(exp);
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0)
            @(negedge CLK);
    endtask

    always @(negedge CLK)
    begin : check_done
        eeprom_pkg::eeprom_result_t exp;
        eeprom_pkg::eeprom_byte_u   exp_ctrl;
        if (!RESET && done)
        begin
            if (exp_q.size() == 0)
                abort_run("done pulse with no pending command");
            else
            begin
                exp = exp_q.pop_front();
                compare_result(result, exp);
                exp_ctrl.ctrl.device_type = `EEPROM_DEVICE_TYPE;
                exp_ctrl.ctrl.block       = exp.addr[10:8];
                exp_ctrl.ctrl.rw          = 1'b0;
                compare_byte(ctrl_wr, exp_ctrl, "first control byte");
                if (exp.is_read && !exp.nack)
                begin
                    exp_ctrl.ctrl.rw = 1'b1;
                    compare_byte(ctrl_rd, exp_ctrl, "control byte after repeated start");
                end
                done_count++;
            end
        end
    end

    always @(dut0.asrt0.fail_count)
    begin
        if (dut0.asrt0.fail_count != 0)
            abort_run("an assertion on the DUT interface failed");
    end

    initial
    begin
        #(WATCHDOG_NS);
        abort_run("timeout, commands did not complete in time");
    end

    initial
    begin
        logic [10:0] a;
        int          n;
        int          prev;
        void'($urandom(4));
        CLK        = 1'b0;
        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wdata      = '0;
        force_nack = 1'b0;
        for (int i = 0; i < 2048; i++)
        begin
            ref_mem[i] = 8'hFF;
            written[i] = 1'b0;
        end
        repeat (10) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        compare_level(full, 1'b0, "full after reset");

        // one write per block, a few more anywhere, then read all back
        for (int i = 0; i < 12; i++)
        begin
            a = (i < 8) ? {3'(i), 8'($urandom)} : 11'($urandom);
            issue_cmd(1'b0, a, 8'($urandom), 1'b0);
            used_addr.push_back(a);
        end
        foreach (used_addr[i])
            issue_cmd(1'b1, used_addr[i], 8'h00, 1'b0);
        wait_idle();

        for (int i = 0; i < 4; i++)
        begin
            a = 11'($urandom);
            while (written[a])
                a = 11'($urandom);
            issue_cmd(1'b1, a, 8'h00, 1'b0);    // never written
        end
        wait_idle();

        for (int b = 0; b < 5; b++)
        begin
            n = 1 + ($urandom % `EEPROM_FIFO_DEPTH);
            for (int i = 0; i < n; i++)
            begin
                a = ($urandom % 2) ? used_addr[$urandom % used_addr.size()] : 11'($urandom);
                issue_cmd(1'($urandom), a, 8'($urandom), 1'b0);
            end
            wait_idle();
        end

        // write refused by the slave must leave memory alone
        a = used_addr[0];
        @(posedge CLK);
        force_nack <= 1'b1;
        issue_cmd(1'b0, a, ~ref_mem[a], 1'b1);
        wait_idle();
        @(posedge CLK);
        force_nack <= 1'b0;
        issue_cmd(1'b1, a, 8'h00, 1'b0);
        wait_idle();

        compare_level(full, 1'b0, "full while idle");
        issue_cmd(1'b1, used_addr[1], 8'h00, 1'b0);
        for (int i = 0; i < `EEPROM_FIFO_DEPTH; i++)
            issue_cmd(1'b0, 11'($urandom), 8'($urandom), 1'b0);
        @(negedge CLK);
        compare_level(full, 1'b1, "full behind a long read");
        prev = done_count;
        while (done_count == prev)
            @(negedge CLK);
        n = 0;
        while (full && (n < 4))
        begin
            @(negedge CLK);
            n++;
        end
        compare_level(full, 1'b0, "full after the next done");
        wait_idle();

        repeat (4) @(negedge CLK);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/eeprom_ctrl_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_assertions
(
    input wire CLK,
    input wire RESET,
    input wire wr,
    input wire rd,
    input wire full,
    input wire done,
    input wire scl,
    input wire sda_low
);

    int fail_count = 0;

    strobes_exclusive: assert property (@(posedge CLK) disable iff (RESET) !(wr && rd))
    else
    begin
        $error("wr and rd high in the same cycle");
        fail_count++;
    end

    // a strobe while full is lost
    no_strobe_when_full: assert property (@(posedge CLK) disable iff (RESET) (wr || rd) |-> !full)
    else
    begin
        $error("host strobe while the command queue is full");
        fail_count++;
    end

    done_single_cycle: assert property (@(posedge CLK) disable iff (RESET) done |=> !done)
    else
    begin
        $error("done held for more than one cycle");
        fail_count++;
    end

    bus_idle_after_reset: assert property (@(posedge CLK) $fell(RESET) |-> (scl && !sda_low))
    else
    begin
        $error("bus not idle right after reset");
        fail_count++;
    end

endmodule

`default_nettype wire

//--- testbench/eeprom_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_cfg.svh"

module eeprom_slave_model
(
    input  wire                      scl,
    input  wire                      sda,
    input  wire                      force_nack,
    output logic                     sda_low,
    output eeprom_pkg::eeprom_byte_u ctrl_wr,    // control bytes of the current transfer
    output eeprom_pkg::eeprom_byte_u ctrl_rd
);

    logic [7:0]               mem [2048];
    logic                     scl_q = 1'b1;
    logic                     sda_q = 1'b1;
    logic                     active = 1'b0;
    logic                     reading = 1'b0;
    logic                     pull = 1'b0;
    logic                     ack_now = 1'b0;
    logic [3:0]               bit_cnt = 4'd0;
    logic [1:0]               byte_idx = 2'd0;
    logic [7:0]               shreg = 8'h00;
    logic [7:0]               tx = 8'h00;
    logic [2:0]               block = 3'd0;
    logic [10:0]              ptr = 11'd0;
    eeprom_pkg::eeprom_byte_u rx = '0;
    eeprom_pkg::eeprom_byte_u ctrl_wr_q = '0;
    eeprom_pkg::eeprom_byte_u ctrl_rd_q = '0;

    assign sda_low = pull;
    assign ctrl_wr = ctrl_wr_q;
    assign ctrl_rd = ctrl_rd_q;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF;    // erased part
    end

    // one complete byte received from the master
    task automatic take_byte();
        rx.raw  = shreg;
        ack_now = !force_nack;
        case (byte_idx)
            2'd0:
            begin
                ack_now = ack_now && (rx.ctrl.device_type == `EEPROM_DEVICE_TYPE);
                if (rx.ctrl.rw)
                    ctrl_rd_q = rx;
                else
                begin
                    ctrl_wr_q = rx;
                    block     = rx.ctrl.block;
                end
            end
            2'd1:    ptr = {block, shreg};
            default:
                if (ack_now)
                    mem[ptr] = shreg;
        endcase
    endtask

    always @(posedge scl or negedge scl or posedge sda or negedge sda)
    begin
        if ((scl !== scl_q) && (scl === 1'b1) && active)
        begin
            if (reading)
            begin
                if (bit_cnt == 4'd9)
                begin
                    reading = 1'b0;    // master ack slot ends the read
                    active  = 1'b0;
                end
            end
            else if (bit_cnt < 4'd8)
            begin
                shreg   = {shreg[6:0], sda};
                bit_cnt = bit_cnt + 1'b1;
                if (bit_cnt == 4'd8)
                    take_byte();
            end
        end
        else if ((scl !== scl_q) && (scl === 1'b0) && active)
        begin
            if (reading)
            begin
                if (bit_cnt < 4'd8)
                begin
                    pull    = !tx[7 - bit_cnt];
                    bit_cnt = bit_cnt + 1'b1;
                end
                else
                begin
                    pull    = 1'b0;
                    bit_cnt = 4'd9;
                end
            end
            else if (bit_cnt == 4'd8)
            begin
                pull    = ack_now;
                bit_cnt = 4'd9;
            end
            else if (bit_cnt == 4'd9)
            begin
                pull    = 1'b0;
                bit_cnt = 4'd0;
                if ((byte_idx == 2'd0) && rx.ctrl.rw && ack_now)
                begin
                    reading = 1'b1;
                    tx      = mem[ptr];
                    pull    = !tx[7];
                    bit_cnt = 4'd1;
                end
                if (byte_idx != 2'd3)
                    byte_idx = byte_idx + 1'b1;
            end
        end
        else if ((sda !== sda_q) && (scl === 1'b1))
        begin
            if (sda === 1'b0)
            begin
                if (!active)
                begin
                    ctrl_wr_q = '0;    // fresh transfer rather than a repeated start
                    ctrl_rd_q = '0;
                end
                active   = 1'b1;
                reading  = 1'b0;
                bit_cnt  = 4'd0;
                byte_idx = 2'd0;
                pull     = 1'b0;
            end
            else if (sda === 1'b1)
            begin
                active  = 1'b0;    // stop
                reading = 1'b0;
                pull    = 1'b0;
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

`default_nettype wire

//--- verilog/eeprom_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_top
(
    input  wire                        CLK,
    input  wire                        RESET,
    input  wire                        wr,
    input  wire                        rd,
    input  wire [10:0]                 addr,
    input  wire [7:0]                  wdata,
    input  wire                        sda_in,
    output logic                       full,
    output logic                       done,
    output eeprom_pkg::eeprom_result_t result,
    output logic                       scl,
    output logic                       sda_low
);

    logic                    push;
    eeprom_pkg::eeprom_cmd_t push_cmd;
    eeprom_pkg::eeprom_cmd_t head;
    logic                    not_empty;
    logic                    pop;
    logic                    start;
    logic                    busy;
    logic                    op_done;
    eeprom_pkg::engine_req_t req;
    eeprom_pkg::engine_rsp_t rsp;

    assign push             = wr | rd;
    assign push_cmd.is_read = rd;
    assign push_cmd.addr    = addr;
    assign push_cmd.data    = wdata;

    eeprom_cmd_fifo fifo0
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .push      (push),
        .push_cmd  (push_cmd),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .full      (full)
    );

    i2c_sequencer seq0
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .not_empty (not_empty),
        .head      (head),
        .busy      (busy),
        .op_done   (op_done),
        .rsp       (rsp),
        .pop       (pop),
        .start     (start),
        .req       (req),
        .done      (done),
        .result    (result)
    );

    i2c_bit_engine eng0
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .start   (start),
        .req     (req),
        .sda_in  (sda_in),
        .busy    (busy),
        .op_done (op_done),
        .rsp     (rsp),
        .scl     (scl),
        .sda_low (sda_low)
    );

endmodule

`default_nettype wire

//--- i2c_master/i2c_bit_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_cfg.svh"

module i2c_bit_engine
(
    input  wire                          CLK,
    input  wire                          RESET,
    input  wire                          start,
    input  wire eeprom_pkg::engine_req_t req,
    input  wire                          sda_in,
    output logic                         busy,
    output logic                         op_done,
    output eeprom_pkg::engine_rsp_t      rsp,
    output logic                         scl,
    output logic                         sda_low
);

    localparam int QUARTER = `EEPROM_SCL_QUARTER;
    localparam int QCNT_W  = (QUARTER > 1) ? $clog2(QUARTER) : 1;

    logic [QCNT_W-1:0] qcnt;
    logic [1:0]        phase;     // scl low in 0 and 1 and high in 2 and 3
    logic [3:0]        bitcnt;
    logic [1:0]        op;
    logic [7:0]        shreg;
    logic              ack_out;
    logic              ack_in;
    logic              tick;
    logic              is_byte;
    logic              last_bit;
    logic              drive_bit;

    assign tick     = (qcnt == QCNT_W'(QUARTER - 1));
    assign is_byte  = (op == `EEPROM_OP_WRITE) || (op == `EEPROM_OP_READ);
    assign last_bit = !is_byte || (bitcnt == 4'd8);

    assign rsp.rx_byte = shreg;
    assign rsp.ack_in  = ack_in;

    // sda level of this bit where 1 releases the line
    always_comb
    begin
        if (bitcnt == 4'd8)
            drive_bit = (op == `EEPROM_OP_WRITE) ? 1'b1 : ack_out;
        else
            drive_bit = (op == `EEPROM_OP_WRITE) ? shreg[7] : 1'b1;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            op_done <= 1'b0;
            scl     <= 1'b1;
            sda_low <= 1'b0;
            qcnt    <= '0;
            phase   <= 2'd0;
            bitcnt  <= 4'd0;
        end
        else
        begin
            op_done <= 1'b0;
            if (!busy)
            begin
                if (start)
                begin
                    busy   <= 1'b1;
                    qcnt   <= '0;
                    phase  <= 2'd0;
                    bitcnt <= 4'd0;
                    scl    <= 1'b0;
                end
            end
            else
            begin
                qcnt <= tick ? '0 : qcnt + 1'b1;
                if (tick)
                begin
                    case (phase)
                        2'd0:
                        begin
                            phase <= 2'd1;
                            if (op == `EEPROM_OP_START)
                                sda_low <= 1'b0;
                            else if (op == `EEPROM_OP_STOP)
                                sda_low <= 1'b1;
                            else
                                sda_low <= ~drive_bit;
                        end
                        2'd1:
                        begin
                            phase <= 2'd2;
                            scl   <= 1'b1;
                        end
                        2'd2:
                        begin
                            phase <= 2'd3;
                            if (op == `EEPROM_OP_START)
                                sda_low <= 1'b1;   // start condition
                            else if (op == `EEPROM_OP_STOP)
                                sda_low <= 1'b0;   // stop condition
                        end
                        default:
                        begin
                            if (last_bit)
                            begin
                                busy    <= 1'b0;   // scl left high
                                op_done <= 1'b1;
                            end
                            else
                            begin
                                bitcnt <= bitcnt + 1'b1;
                                phase  <= 2'd0;
                                scl    <= 1'b0;
                            end
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (start && !busy)
        begin
            op      <= req.op;
            shreg   <= req.tx_byte.raw;
            ack_out <= req.ack_out;
        end
        else if (busy && tick && (phase == 2'd2) && is_byte)
        begin
            if (bitcnt == 4'd8)
                ack_in <= ~sda_in;                // pulled low means ack
            else
                shreg <= {shreg[6:0], sda_in};    // mid high sample
        end
    end

endmodule

`default_nettype wire

//--- i2c_master/i2c_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_cfg.svh"

module i2c_sequencer
(
    input  wire                          CLK,
    input  wire                          RESET,
    input  wire                          not_empty,
    input  wire eeprom_pkg::eeprom_cmd_t head,
    input  wire                          busy,
    input  wire                          op_done,
    input  wire eeprom_pkg::engine_rsp_t rsp,
    output logic                         pop,
    output logic                         start,
    output eeprom_pkg::engine_req_t      req,
    output logic                         done,
    output eeprom_pkg::eeprom_result_t   result
);

    localparam logic [9:0] ST_IDLE    = 10'b00_0000_0001;
    localparam logic [9:0] ST_START   = 10'b00_0000_0010;
    localparam logic [9:0] ST_CTRL_WR = 10'b00_0000_0100;
    localparam logic [9:0] ST_ADDR    = 10'b00_0000_1000;
    localparam logic [9:0] ST_DATA_WR = 10'b00_0001_0000;
    localparam logic [9:0] ST_RSTART  = 10'b00_0010_0000;
    localparam logic [9:0] ST_CTRL_RD = 10'b00_0100_0000;
    localparam logic [9:0] ST_DATA_RD = 10'b00_1000_0000;
    localparam logic [9:0] ST_STOP    = 10'b01_0000_0000;
    localparam logic [9:0] ST_REPORT  = 10'b10_0000_0000;

    logic [9:0]               state;
    logic [9:0]               write_next;
    logic                     issued;      // engine op of this step is running
    logic                     step_done;
    logic                     nack;
    logic [7:0]               data_r;
    eeprom_pkg::eeprom_cmd_t  cmd;
    eeprom_pkg::eeprom_byte_u ctrl_byte;

    assign pop       = (state == ST_IDLE) && not_empty;
    assign start     = (state != ST_IDLE) && (state != ST_REPORT) && !issued && !busy;
    assign step_done = issued && op_done;
    assign done      = (state == ST_REPORT);

    assign result.is_read = cmd.is_read;
    assign result.nack    = nack;
    assign result.addr    = cmd.addr;
    assign result.data    = data_r;

    always_comb
    begin
        ctrl_byte.ctrl.device_type = `EEPROM_DEVICE_TYPE;
        ctrl_byte.ctrl.block       = cmd.addr[10:8];
        ctrl_byte.ctrl.rw          = (state == ST_CTRL_RD);
    end

    always_comb
    begin
        req.op          = `EEPROM_OP_WRITE;
        req.tx_byte.raw = 8'h00;
        req.ack_out     = 1'b1;   // nack ends the single byte read
        case (state)
            ST_START, ST_RSTART:    req.op = `EEPROM_OP_START;
            ST_CTRL_WR, ST_CTRL_RD: req.tx_byte = ctrl_byte;
            ST_ADDR:                req.tx_byte.raw = cmd.addr[7:0];
            ST_DATA_WR:             req.tx_byte.raw = cmd.data;
            ST_DATA_RD:             req.op = `EEPROM_OP_READ;
            ST_STOP:                req.op = `EEPROM_OP_STOP;
            default:                req.op = `EEPROM_OP_WRITE;
        endcase
    end

    // successor of a written byte that got its ack
    always_comb
    begin
        case (state)
            ST_CTRL_WR: write_next = ST_ADDR;
            ST_ADDR:    write_next = cmd.is_read ? ST_RSTART : ST_DATA_WR;
            ST_CTRL_RD: write_next = ST_DATA_RD;
            default:    write_next = ST_STOP;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= ST_IDLE;
            issued <= 1'b0;
            nack   <= 1'b0;
        end
        else
        begin
            if (start)
                issued <= 1'b1;
            else if (step_done)
                issued <= 1'b0;

            case (state)
                ST_IDLE:
                    if (not_empty)
                    begin
                        nack  <= 1'b0;
                        state <= ST_START;
                    end
                ST_START:
                    if (step_done)
                        state <= ST_CTRL_WR;
                ST_RSTART:
                    if (step_done)
                        state <= ST_CTRL_RD;
                ST_CTRL_WR, ST_ADDR, ST_DATA_WR, ST_CTRL_RD:
                    if (step_done)
                    begin
                        if (!rsp.ack_in)
                        begin
                            nack  <= 1'b1;      // abort with a stop
                            state <= ST_STOP;
                        end
                        else
                            state <= write_next;
                    end
                ST_DATA_RD:
                    if (step_done)
                        state <= ST_STOP;
                ST_STOP:
                    if (step_done)
                        state <= ST_REPORT;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (pop)
        begin
            cmd    <= head;
            data_r <= head.data;
        end
        else if ((state == ST_DATA_RD) && step_done)
            data_r <= rsp.rx_byte;
    end

endmodule

`default_nettype wire

//--- verilog/eeprom_cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_cfg.svh"

module eeprom_cmd_fifo
(
    input  wire                          CLK,
    input  wire                          RESET,
    input  wire                          push,
    input  wire eeprom_pkg::eeprom_cmd_t push_cmd,
    input  wire                          pop,
    output eeprom_pkg::eeprom_cmd_t      head,
    output logic                         not_empty,
    output logic                         full
);

    localparam int DEPTH = `EEPROM_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    eeprom_pkg::eeprom_cmd_t mem [DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [CNT_W-1:0]        count;
    logic                    do_push;
    logic                    do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(DEPTH));
    assign not_empty = (count != '0);
    assign do_push   = push && !full;     // dropped when full
    assign do_pop    = pop && not_empty;
    assign head      = mem[rd_ptr];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // none or both
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (do_push)
            mem[wr_ptr] <= push_cmd;
    end

endmodule

`default_nettype wire

//--- common/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    typedef struct packed {
        logic        is_read;
        logic [10:0] addr;
        logic [7:0]  data;     // unused for reads
    } eeprom_cmd_t;

    typedef struct packed {
        logic        is_read;
        logic        nack;
        logic [10:0] addr;
        logic [7:0]  data;     // read byte or written byte
    } eeprom_result_t;

    typedef struct packed {
        logic [3:0] device_type;
        logic [2:0] block;     // addr[10:8]
        logic       rw;
    } ctrl_byte_t;

    // one serial byte as raw bits or as control byte
    typedef union packed {
        logic [7:0] raw;
        ctrl_byte_t ctrl;
    } eeprom_byte_u;

    typedef struct packed {
        logic [1:0]   op;
        eeprom_byte_u tx_byte;
        logic         ack_out;   // level driven in the ack slot of a read
    } engine_req_t;

    typedef struct packed {
        logic [7:0] rx_byte;
        logic       ack_in;
    } engine_rsp_t;

endpackage

`default_nettype wire

//--- common/eeprom_cfg.svh
`ifndef EEPROM_CFG_SVH
`define EEPROM_CFG_SVH

// depth of the host command queue
`define EEPROM_FIFO_DEPTH  4

// CLK cycles per quarter of an scl period
`define EEPROM_SCL_QUARTER 2

// fixed upper nibble of the control byte
`define EEPROM_DEVICE_TYPE 4'b1010

// bit engine op codes
`define EEPROM_OP_START    2'd0
`define EEPROM_OP_STOP     2'd1
`define EEPROM_OP_WRITE    2'd2
`define EEPROM_OP_READ     2'd3

`endif
